// ==== Bender.yml ====
package:
  name: lane_operand_bus

sources:
  - hdl/lane_op_pkg.sv
  - hdl/lane_bus_pkg.sv
  - hdl/bus_insn_decoder.sv
  - hdl/bus_order_fifo.sv
  - hdl/operand_bus_router.sv
  - hdl/lane_operand_bus.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_lane_operand_bus.sv

// ==== hdl/bus_insn_decoder.sv ====
// Issue register and classifier turning vector operations into operand bus selections
`timescale 1ns/10ps
`default_nettype none

module bus_insn_decoder (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  lane_bus_pkg::vfu_issue_t vfu_issue_i,
  output logic                   push_o,
  output lane_bus_pkg::bus_sel_e push_sel_o
);

  import lane_op_pkg::*;
  import lane_bus_pkg::*;

  //////////////////////////////
  // Issue register
  //////////////////////////////

  logic    issue_valid_q;
  ara_op_e issue_op_q;

  // Cuts the path from the sequencer to the FIFO
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      issue_valid_q <= 1'b0;
    end else begin
      issue_valid_q <= vfu_issue_i.valid;
    end
  end

  // Registered opcode
  always_ff @(posedge clk_i) begin
    issue_op_q <= vfu_issue_i.op;
  end

  //////////////////////////////
  // Classification
  //////////////////////////////

  always_comb begin
    push_o     = 1'b0;
    push_sel_o = SLDU_SEL;

    if (issue_valid_q) begin
      case (issue_op_q) inside
        VSLIDEUP, VSLIDEDOWN: begin
          push_o     = 1'b1;
          push_sel_o = SLDU_SEL;
        end
        VLXE, VSXE: begin
          push_o     = 1'b1;
          push_sel_o = ADDRGEN_SEL;
        end
        [VREDSUM:VWREDSUM]: begin
          push_o     = 1'b1;
          push_sel_o = ALU_RED_SEL;
        end
        [VFREDUSUM:VFWREDOSUM]: begin
          push_o     = 1'b1;
          push_sel_o = FPU_RED_SEL;
        end
        // Arithmetic ops never touch the shared bus
        default: begin
          push_o = 1'b0;
        end
      endcase
    end
  end

endmodule : bus_insn_decoder

`default_nettype wire

// ==== hdl/bus_order_fifo.sv ====
// In-order FIFO of pending bus users, retired by the completion pulse of the head's kind
`timescale 1ns/10ps
`default_nettype none

module bus_order_fifo (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    flush_i,
  input  logic                    push_i,
  input  lane_bus_pkg::bus_sel_e  push_sel_i,
  input  logic                    cmd_pop_i,
  input  logic                    alu_red_done_i,
  input  logic                    fpu_red_done_i,
  output lane_bus_pkg::bus_head_t head_o
);

  import lane_bus_pkg::*;

  //////////////////////////////
  // Storage and pointers
  //////////////////////////////

  bus_sel_e                     sel_mem [NrVInsn];
  logic [$clog2(NrVInsn)-1:0]   rd_ptr_q;
  logic [$clog2(NrVInsn)-1:0]   wr_ptr_q;
  logic [OrderCntWidth-1:0]     count_q;

  logic     empty;
  logic     full;
  logic     head_done;
  logic     push_en;
  logic     pop_en;
  bus_sel_e head_sel;

  assign empty    = (count_q == '0);
  assign full     = (count_q == OrderCntWidth'(NrVInsn));
  assign head_sel = sel_mem[rd_ptr_q];

  //////////////////////////////
  // Retirement
  //////////////////////////////

  // Slides and address generation share the operand queue pop
  always_comb begin
    case (head_sel)
      SLDU_SEL:    head_done = cmd_pop_i;
      ADDRGEN_SEL: head_done = cmd_pop_i;
      ALU_RED_SEL: head_done = alu_red_done_i;
      FPU_RED_SEL: head_done = fpu_red_done_i;
      default:     head_done = 1'b0;
    endcase
  end

  assign pop_en  = !empty && head_done && !flush_i;
  // A push in the flush cycle is lost with the rest
  assign push_en = push_i && !full && !flush_i;

  always_ff @(posedge clk_i) begin
    if (push_en) begin
      sel_mem[wr_ptr_q] <= push_sel_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + OrderCntWidth'(push_en) - OrderCntWidth'(pop_en);
    end
  end

  assign head_o.valid = !empty;
  assign head_o.sel   = head_sel;

  //////////////////////////////
  // Assertions
  //////////////////////////////

  // Decoder must never issue past the FIFO depth
  no_push_when_full: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (full && !flush_i) |-> !push_i
  ) else $error("bus_order_fifo: push into full FIFO dropped");

  count_in_range: assert property (
    @(posedge clk_i) disable iff (reset_i)
    count_q <= OrderCntWidth'(NrVInsn)
  ) else $error("bus_order_fifo: occupancy above depth");

endmodule : bus_order_fifo

`default_nettype wire

// ==== hdl/lane_bus_pkg.sv ====
// Bus selection types, order FIFO constants and stream structs of the lane operand bus
`default_nettype none

package lane_bus_pkg;

  //////////////////////////////
  // Order FIFO
  //////////////////////////////

  // Maximum number of pending bus users
  localparam int unsigned NrVInsn = 8;

  // Occupancy counter, counts 0 to NrVInsn inclusive
  localparam int unsigned OrderCntWidth = 4;

  //////////////////////////////
  // Bus users
  //////////////////////////////

  typedef enum logic [1:0] {
    SLDU_SEL    = 2'd0,
    ADDRGEN_SEL = 2'd1,
    ALU_RED_SEL = 2'd2,
    FPU_RED_SEL = 2'd3
  } bus_sel_e;

  //////////////////////////////
  // Structs
  //////////////////////////////

  // Operation issued to the lane FUs
  typedef struct packed {
    logic                valid;
    lane_op_pkg::ara_op_e op;
  } vfu_issue_t;

  // One beat of a data stream
  typedef struct packed {
    logic               valid;
    lane_op_pkg::elen_t data;
  } operand_stream_t;

  // Current owner of the bus, valid only when the FIFO holds an entry
  typedef struct packed {
    logic     valid;
    bus_sel_e sel;
  } bus_head_t;

endpackage : lane_bus_pkg

`default_nettype wire

// ==== hdl/lane_op_pkg.sv ====
// Vector operation opcodes and lane datapath widths shared by the operand bus logic
`default_nettype none

package lane_op_pkg;

  //////////////////////////////
  // Datapath
  //////////////////////////////

  // Lane datapath width in bits
  localparam int unsigned ElenWidth = 64;

  // One element word on the lane bus
  typedef logic [ElenWidth-1:0] elen_t;

  //////////////////////////////
  // Opcodes
  //////////////////////////////

  // Reduction groups must stay contiguous, the decoder matches them as ranges
  typedef enum logic [4:0] {
    // Plain arithmetic, never uses the shared bus
    VADD       = 5'd0,
    VSUB       = 5'd1,
    VMUL       = 5'd2,
    // Slides
    VSLIDEUP   = 5'd3,
    VSLIDEDOWN = 5'd4,
    // Indexed memory operations
    VLXE       = 5'd5,
    VSXE       = 5'd6,
    // Integer reductions
    VREDSUM    = 5'd7,
    VREDAND    = 5'd8,
    VREDOR     = 5'd9,
    VWREDSUM   = 5'd10,
    // Floating-point reductions
    VFREDUSUM  = 5'd11,
    VFREDOSUM  = 5'd12,
    VFWREDUSUM = 5'd13,
    VFWREDOSUM = 5'd14
  } ara_op_e;

endpackage : lane_op_pkg

`default_nettype wire

// ==== hdl/lane_operand_bus.sv ====
// Lane operand bus arbitration joining the issue decoder, order FIFO and stream router
`timescale 1ns/10ps
`default_nettype none

module lane_operand_bus (
  input  logic                          clk_i,
  input  logic                          reset_i,
  // Issued operations
  input  lane_bus_pkg::vfu_issue_t      vfu_issue_i,
  // Source streams
  input  lane_bus_pkg::operand_stream_t opq_operand_i,
  input  lane_bus_pkg::operand_stream_t alu_red_operand_i,
  input  lane_bus_pkg::operand_stream_t fpu_red_operand_i,
  // Sink readiness
  input  logic                          sldu_ready_i,
  input  logic                          addrgen_ready_i,
  // Completion and flush pulses
  input  logic                          cmd_pop_i,
  input  logic                          alu_red_done_i,
  input  logic                          fpu_red_done_i,
  input  logic                          flush_i,
  // Slide unit reduction side
  input  logic                          sldu_red_valid_i,
  input  logic                          opq_result_gnt_i,
  input  logic                          alu_red_ready_i,
  input  logic                          fpu_red_ready_i,
  // Routed outputs
  output lane_bus_pkg::operand_stream_t sldu_operand_o,
  output logic                          addrgen_valid_o,
  output logic                          opq_ready_o,
  output logic                          alu_red_gnt_o,
  output logic                          fpu_red_gnt_o,
  output logic                          sldu_alu_valid_o,
  output logic                          sldu_fpu_valid_o,
  output logic                          sldu_result_gnt_o
);

  import lane_bus_pkg::*;

  logic      push;
  bus_sel_e  push_sel;
  bus_head_t head;

  //////////////////////////////
  // Issue decode
  //////////////////////////////

  bus_insn_decoder u_decoder (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .vfu_issue_i(vfu_issue_i),
    .push_o     (push),
    .push_sel_o (push_sel)
  );

  //////////////////////////////
  // Order FIFO
  //////////////////////////////

  bus_order_fifo u_order_fifo (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .flush_i       (flush_i),
    .push_i        (push),
    .push_sel_i    (push_sel),
    .cmd_pop_i     (cmd_pop_i),
    .alu_red_done_i(alu_red_done_i),
    .fpu_red_done_i(fpu_red_done_i),
    .head_o        (head)
  );

  //////////////////////////////
  // Router
  //////////////////////////////

  operand_bus_router u_router (
    .head_i           (head),
    .opq_operand_i    (opq_operand_i),
    .alu_red_operand_i(alu_red_operand_i),
    .fpu_red_operand_i(fpu_red_operand_i),
    .sldu_ready_i     (sldu_ready_i),
    .addrgen_ready_i  (addrgen_ready_i),
    .sldu_red_valid_i (sldu_red_valid_i),
    .opq_result_gnt_i (opq_result_gnt_i),
    .alu_red_ready_i  (alu_red_ready_i),
    .fpu_red_ready_i  (fpu_red_ready_i),
    .sldu_operand_o   (sldu_operand_o),
    .addrgen_valid_o  (addrgen_valid_o),
    .opq_ready_o      (opq_ready_o),
    .alu_red_gnt_o    (alu_red_gnt_o),
    .fpu_red_gnt_o    (fpu_red_gnt_o),
    .sldu_alu_valid_o (sldu_alu_valid_o),
    .sldu_fpu_valid_o (sldu_fpu_valid_o),
    .sldu_result_gnt_o(sldu_result_gnt_o)
  );

endmodule : lane_operand_bus

`default_nettype wire

// ==== hdl/operand_bus_router.sv ====
// Combinational router of the shared slide/address-generator bus driven by the FIFO head
`timescale 1ns/10ps
`default_nettype none

module operand_bus_router (
  input  lane_bus_pkg::bus_head_t       head_i,
  input  lane_bus_pkg::operand_stream_t opq_operand_i,
  input  lane_bus_pkg::operand_stream_t alu_red_operand_i,
  input  lane_bus_pkg::operand_stream_t fpu_red_operand_i,
  input  logic                          sldu_ready_i,
  input  logic                          addrgen_ready_i,
  input  logic                          sldu_red_valid_i,
  input  logic                          opq_result_gnt_i,
  input  logic                          alu_red_ready_i,
  input  logic                          fpu_red_ready_i,
  output lane_bus_pkg::operand_stream_t sldu_operand_o,
  output logic                          addrgen_valid_o,
  output logic                          opq_ready_o,
  output logic                          alu_red_gnt_o,
  output logic                          fpu_red_gnt_o,
  output logic                          sldu_alu_valid_o,
  output logic                          sldu_fpu_valid_o,
  output logic                          sldu_result_gnt_o
);

  import lane_op_pkg::*;
  import lane_bus_pkg::*;

  //////////////////////////////
  // Stream mux
  //////////////////////////////

  elen_t bus_data;
  logic  bus_valid;

  // Everything stays quiet while no user owns the bus
  always_comb begin
    bus_data          = opq_operand_i.data;
    bus_valid         = 1'b0;
    addrgen_valid_o   = 1'b0;
    opq_ready_o       = 1'b0;
    alu_red_gnt_o     = 1'b0;
    fpu_red_gnt_o     = 1'b0;
    sldu_alu_valid_o  = 1'b0;
    sldu_fpu_valid_o  = 1'b0;
    sldu_result_gnt_o = 1'b0;

    if (head_i.valid) begin
      case (head_i.sel)
        SLDU_SEL: begin
          bus_valid         = opq_operand_i.valid;
          opq_ready_o       = sldu_ready_i;
          sldu_result_gnt_o = opq_result_gnt_i;
        end
        // Same data lines, but the valid goes to the address generator
        ADDRGEN_SEL: begin
          addrgen_valid_o = opq_operand_i.valid;
          opq_ready_o     = addrgen_ready_i;
        end
        ALU_RED_SEL: begin
          bus_data          = alu_red_operand_i.data;
          bus_valid         = alu_red_operand_i.valid;
          alu_red_gnt_o     = sldu_ready_i;
          sldu_alu_valid_o  = sldu_red_valid_i;
          sldu_result_gnt_o = alu_red_ready_i;
        end
        FPU_RED_SEL: begin
          bus_data          = fpu_red_operand_i.data;
          bus_valid         = fpu_red_operand_i.valid;
          fpu_red_gnt_o     = sldu_ready_i;
          sldu_fpu_valid_o  = sldu_red_valid_i;
          sldu_result_gnt_o = fpu_red_ready_i;
        end
        default: begin
          bus_valid = 1'b0;
        end
      endcase
    end
  end

  assign sldu_operand_o.valid = bus_valid;
  assign sldu_operand_o.data  = bus_data;

  //////////////////////////////
  // Assertions
  //////////////////////////////

  // Only one source may see a grant on the shared bus
  grant_onehot: assert final ($onehot0({opq_ready_o, alu_red_gnt_o, fpu_red_gnt_o}))
    else $error("operand_bus_router: more than one source granted");

endmodule : operand_bus_router

`default_nettype wire

// ==== lane_operand_bus.f ====
hdl/lane_op_pkg.sv
hdl/lane_bus_pkg.sv
hdl/bus_insn_decoder.sv
hdl/bus_order_fifo.sv
hdl/operand_bus_router.sv
hdl/lane_operand_bus.sv
tests/tb_clock_gen.sv
tests/tb_lane_operand_bus.sv

// ==== tests/tb_clock_gen.sv ====
// Testbench clock and reset source with an 8 ns period and a 5-cycle reset
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Released on a falling edge so the DUT sees a clean first active cycle
  initial begin
    reset_o = 1'b1;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule : tb_clock_gen

`default_nettype wire

// ==== tests/tb_lane_operand_bus.sv ====
// Testbench of the lane operand bus with random streams checked against a queue model
`timescale 1ns/10ps
`default_nettype none

module tb_lane_operand_bus;

  import lane_op_pkg::*;
  import lane_bus_pkg::*;

  // All routed outputs of one cycle
  typedef struct packed {
    logic  sldu_valid;
    logic  addrgen_valid;
    logic  opq_ready;
    logic  alu_gnt;
    logic  fpu_gnt;
    logic  alu_valid;
    logic  fpu_valid;
    logic  result_gnt;
    elen_t data;
  } route_t;

  logic            clk, reset;
  vfu_issue_t      vfu_issue;
  operand_stream_t opq_operand, alu_red_operand, fpu_red_operand, sldu_operand;
  logic            sldu_ready, addrgen_ready, cmd_pop, alu_red_done, fpu_red_done, flush;
  logic            sldu_red_valid, opq_result_gnt, alu_red_ready, fpu_red_ready;
  logic            addrgen_valid, opq_ready, alu_red_gnt, fpu_red_gnt;
  logic            sldu_alu_valid, sldu_fpu_valid, sldu_result_gnt;

  // Model: pending selections in order, plus the registered issue
  bus_sel_e sel_queue[$];
  logic     pend_valid;
  bus_sel_e pend_sel;

  tb_clock_gen u_clock_gen (.clk_o(clk), .reset_o(reset));

  lane_operand_bus UUT (
    .clk_i(clk), .reset_i(reset), .vfu_issue_i(vfu_issue),
    .opq_operand_i(opq_operand), .alu_red_operand_i(alu_red_operand),
    .fpu_red_operand_i(fpu_red_operand), .sldu_ready_i(sldu_ready),
    .addrgen_ready_i(addrgen_ready), .cmd_pop_i(cmd_pop), .alu_red_done_i(alu_red_done),
    .fpu_red_done_i(fpu_red_done), .flush_i(flush), .sldu_red_valid_i(sldu_red_valid),
    .opq_result_gnt_i(opq_result_gnt), .alu_red_ready_i(alu_red_ready),
    .fpu_red_ready_i(fpu_red_ready), .sldu_operand_o(sldu_operand),
    .addrgen_valid_o(addrgen_valid), .opq_ready_o(opq_ready), .alu_red_gnt_o(alu_red_gnt),
    .fpu_red_gnt_o(fpu_red_gnt), .sldu_alu_valid_o(sldu_alu_valid),
    .sldu_fpu_valid_o(sldu_fpu_valid), .sldu_result_gnt_o(sldu_result_gnt)
  );

  task automatic abort_run(input string line);
    $display("TESTBENCH FAILED");
    $display("%s", line);
    $fatal(1);
  endtask

  // Bus user of an opcode; valid low means the op stays off the bus
  function automatic bus_head_t classify_op(input ara_op_e op);
    bus_head_t res;
    res = '{valid: 1'b1, sel: SLDU_SEL};
    if (op inside {VLXE, VSXE}) begin
      res.sel = ADDRGEN_SEL;
    end else if (op inside {VREDSUM, VREDAND, VREDOR, VWREDSUM}) begin
      res.sel = ALU_RED_SEL;
    end else if (op inside {VFREDUSUM, VFREDOSUM, VFWREDUSUM, VFWREDOSUM}) begin
      res.sel = FPU_RED_SEL;
    end else if (!(op inside {VSLIDEUP, VSLIDEDOWN})) begin
      res.valid = 1'b0;
    end
    return res;
  endfunction

  function automatic route_t expected_route();
    route_t exp;
    exp = '0;
    if (sel_queue.size() != 0) begin
      case (sel_queue[0])
        SLDU_SEL: begin
          exp = '{sldu_valid: opq_operand.valid, opq_ready: sldu_ready,
                  result_gnt: opq_result_gnt, data: opq_operand.data, default: 1'b0};
        end
        ADDRGEN_SEL: begin
          exp = '{addrgen_valid: opq_operand.valid, opq_ready: addrgen_ready,
                  data: opq_operand.data, default: 1'b0};
        end
        ALU_RED_SEL: begin
          exp = '{sldu_valid: alu_red_operand.valid, alu_gnt: sldu_ready,
                  alu_valid: sldu_red_valid, result_gnt: alu_red_ready,
                  data: alu_red_operand.data, default: 1'b0};
        end
        default: begin
          exp = '{sldu_valid: fpu_red_operand.valid, fpu_gnt: sldu_ready,
                  fpu_valid: sldu_red_valid, result_gnt: fpu_red_ready,
                  data: fpu_red_operand.data, default: 1'b0};
        end
      endcase
    end
    return exp;
  endfunction

  // One clock edge of the model, using the inputs held during that edge
  task automatic update_model();
    bus_head_t decoded;
    logic      room;
    logic      done;
    decoded = classify_op(vfu_issue.op);
    room    = sel_queue.size() < NrVInsn;
    if (flush) begin
      sel_queue.delete();
    end else begin
      if (sel_queue.size() != 0) begin
        case (sel_queue[0])
          ALU_RED_SEL: done = alu_red_done;
          FPU_RED_SEL: done = fpu_red_done;
          default:     done = cmd_pop;
        endcase
        if (done) begin
          void'(sel_queue.pop_front());
        end
      end
      if (pend_valid && room) begin
        sel_queue.push_back(pend_sel);
      end
    end
    pend_valid = vfu_issue.valid && decoded.valid;
    pend_sel   = decoded.sel;
  endtask

  task automatic check_outputs();
    route_t got;
    route_t exp;
    got = {sldu_operand.valid, addrgen_valid, opq_ready, alu_red_gnt, fpu_red_gnt,
           sldu_alu_valid, sldu_fpu_valid, sldu_result_gnt, sldu_operand.data};
    exp = expected_route();
    // Data lines carry no meaning without a head
    if (sel_queue.size() == 0) begin
      got.data = '0;
    end
    assert (got === exp)
      else abort_run($sformatf("error: %0t: routed outputs %h, expected %h", $time, got, exp));
  endtask

  // Pulses are {cmd_pop, alu_red_done, fpu_red_done}
  task automatic drive_cycle(input logic issue, input ara_op_e op, input logic [2:0] pulses,
                             input logic flush_req);
    vfu_issue = '{valid: issue, op: op};
    {cmd_pop, alu_red_done, fpu_red_done} = pulses;
    flush = flush_req;
    opq_operand     = {1'($urandom), $urandom, $urandom};
    alu_red_operand = {1'($urandom), $urandom, $urandom};
    fpu_red_operand = {1'($urandom), $urandom, $urandom};
    {sldu_ready, addrgen_ready, sldu_red_valid} = 3'($urandom);
    {opq_result_gnt, alu_red_ready, fpu_red_ready} = 3'($urandom);
    @(negedge clk);
    update_model();
    check_outputs();
  endtask

  task automatic idle_cycle();
    drive_cycle(1'b0, VADD, 3'b000, 1'b0);
  endtask

  function automatic logic [2:0] random_pulses();
    return {$urandom_range(3, 0) == 0, $urandom_range(3, 0) == 0, $urandom_range(3, 0) == 0};
  endfunction

  task automatic wait_head_open(output int cycles);
    cycles = 0;
    while (!UUT.head.valid) begin
      if (cycles == 10) begin
        abort_run("Timed out waiting for the bus head to open");
      end else begin
        idle_cycle();
        cycles++;
      end
    end
  endtask

  // Issue one op, check its latency, then retire it with the right pulse only
  task automatic run_single(input ara_op_e op);
    bus_head_t  kind;
    logic [2:0] right;
    int         cycles;
    kind  = classify_op(op);
    right = (kind.sel == ALU_RED_SEL) ? 3'b010 : (kind.sel == FPU_RED_SEL) ? 3'b001 : 3'b100;
    drive_cycle(1'b1, op, 3'b000, 1'b0);
    wait_head_open(cycles);
    assert (cycles == 1) else abort_run($sformatf("error: %0t: %s opened after %0d cycles",
                                                  $time, op.name(), cycles + 1));
    repeat (6) idle_cycle();
    drive_cycle(1'b0, VADD, ~right, 1'b0);
    assert (UUT.head.valid)
      else abort_run($sformatf("error: %0t: %s retired by a foreign pulse", $time, op.name()));
    drive_cycle(1'b0, VADD, right, 1'b0);
    assert (!UUT.head.valid)
      else abort_run($sformatf("error: %0t: %s not retired", $time, op.name()));
  endtask

  initial begin
    int cycles;
    void'($urandom(15));
    vfu_issue = '0;
    {opq_operand, alu_red_operand, fpu_red_operand} = '0;
    {sldu_ready, addrgen_ready, cmd_pop, alu_red_done, fpu_red_done, flush} = '0;
    {sldu_red_valid, opq_result_gnt, alu_red_ready, fpu_red_ready} = '0;
    pend_valid = 1'b0;
    pend_sel   = SLDU_SEL;
    cycles     = 0;
    while (reset !== 1'b0) begin
      if (cycles == 20) begin
        abort_run("Reset was never released");
      end else begin
        @(negedge clk);
        cycles++;
      end
    end

    // Quiet bus after reset, whatever the sources do
    repeat (10) idle_cycle();

    run_single(VSLIDEUP);
    run_single(VLXE);
    run_single(VSXE);
    run_single(VREDAND);
    run_single(VFWREDOSUM);

    // Random mixes, non-bus ops included
    for (int round = 0; round < 20; round++) begin
      repeat ($urandom_range(8, 1)) begin
        drive_cycle(1'($urandom), ara_op_e'($urandom_range(14, 0)), random_pulses(), 1'b0);
      end
      cycles = 0;
      while (sel_queue.size() != 0 || pend_valid || UUT.head.valid) begin
        if (cycles == 200) begin
          abort_run("Timed out draining the order FIFO");
        end else begin
          drive_cycle(1'b0, VADD, random_pulses(), 1'b0);
          cycles++;
        end
      end
    end

    // Flush drops both the queued entries and the push of the flush cycle
    drive_cycle(1'b1, VSLIDEDOWN, 3'b000, 1'b0);
    drive_cycle(1'b1, VLXE, 3'b000, 1'b0);
    drive_cycle(1'b1, VREDOR, 3'b000, 1'b0);
    drive_cycle(1'b0, VADD, 3'b000, 1'b1);
    assert (!UUT.head.valid) else abort_run($sformatf("error: %0t: flush left a head", $time));
    repeat (4) idle_cycle();

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule : tb_lane_operand_bus

`default_nettype wire
